/* display_timings.sv */
// 640x480 screen position counters with sync and frame strobe
// sx/sy start at 0,0 in the first cycle after reset release
`timescale 1ns/10ps

module display_timings (
    input  logic                      clk_pix,
    input  logic                      rst_n,
    output logic [fb_pkg::CORDW-1:0]  sx,     // column 0..799
    output logic [fb_pkg::CORDW-1:0]  sy,     // row 0..524
    output logic                      hsync,  // active low
    output logic                      vsync,  // active low
    output logic                      frame   // first active pixel
);

    // sync windows, both negative polarity
    localparam logic [fb_pkg::CORDW-1:0] HS_STA = fb_pkg::H_ACTIVE + fb_pkg::H_FRONT;
    localparam logic [fb_pkg::CORDW-1:0] HS_END = HS_STA + fb_pkg::H_SYNC;
    localparam logic [fb_pkg::CORDW-1:0] VS_STA = fb_pkg::V_ACTIVE + fb_pkg::V_FRONT;
    localparam logic [fb_pkg::CORDW-1:0] VS_END = VS_STA + fb_pkg::V_SYNC;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == fb_pkg::H_TOTAL - 1'b1) begin  // end of line
            sx <= '0;
            if (sy == fb_pkg::V_TOTAL - 1'b1) begin  // wrap frame
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decoded straight from the counters
    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);  // 656..751
        vsync = ~(sy >= VS_STA && sy < VS_END);  // 490..491
        frame = (sx == '0) && (sy == '0);
    end

endmodule

/* fb_apb_regs.sv */
// APB slave with the command and status registers
// pokes go to the arbiter, line commands go to the drawer with a start strobe
`timescale 1ns/10ps

module fb_apb_regs (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              busy,    // drawer running
    output logic              start,   // one cycle, cmd valid with it
    output fb_pkg::fb_cmd_u   cmd,     // held line command
    fb_wr_if.master           poke
);

    fb_pkg::fb_cmd_u wcmd;  // incoming word, both views
    logic access, cmd_hit, sts_hit, is_line, is_poke, stall, wr_acc;
    logic poke_pend;

    always_comb begin
        wcmd    = pwdata;
        access  = psel && penable;
        cmd_hit = (paddr == fb_pkg::ADDR_CMD);
        sts_hit = (paddr == fb_pkg::ADDR_STATUS);
        is_line = (wcmd.line.op == fb_pkg::OP_HLINE) || (wcmd.line.op == fb_pkg::OP_VLINE);
        is_poke = (wcmd.pix.op == fb_pkg::OP_POKE);
        // hold the bus while the target is still occupied
        stall   = access && pwrite && cmd_hit &&
                  ((is_line && (busy || start)) || (is_poke && poke_pend));
        pready  = ~stall;
        pslverr = access && !cmd_hit && !sts_hit;  // unknown offset
        wr_acc  = access && pwrite && cmd_hit && !stall;
        prdata  = '0;
        if (sts_hit) prdata = {30'b0, poke_pend, busy};
        else if (cmd_hit) prdata = cmd;  // last line command
    end

    // control state
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            start     <= 1'b0;
            poke_pend <= 1'b0;
        end else begin
            start <= wr_acc && is_line;
            if (wr_acc && is_poke && wcmd.pix.addr < fb_pkg::FB_PIXELS) begin
                poke_pend <= 1'b1;  // out of range pokes dropped here
            end else if (poke.gnt) begin
                poke_pend <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk_pix) begin
        if (wr_acc && is_line) cmd <= wcmd;
        if (wr_acc && is_poke) begin
            poke.addr <= wcmd.pix.addr;
            poke.colr <= wcmd.pix.colr;
        end
    end

    assign poke.req = poke_pend;  // held until granted

endmodule

/* fb_arbiter.sv */
// round-robin arbiter, two write masters onto the single RAM write port
// grant is combinational, write lands at the grant edge
`timescale 1ns/10ps

module fb_arbiter (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    fb_wr_if.arbiter                      m0,     // APB pokes
    fb_wr_if.arbiter                      m1,     // line drawer
    output logic                          we,
    output logic [fb_pkg::FB_ADDRW-1:0]   waddr,
    output logic [fb_pkg::COLRW-1:0]      wdata
);

    logic prio;  // 0 favours m0 when both ask

    always_comb begin
        m0.gnt = m0.req && (!m1.req || !prio);
        m1.gnt = m1.req && (!m0.req || prio);
        we     = m0.gnt || m1.gnt;
        // steer the winner, m0 by default
        waddr  = m1.gnt ? m1.addr : m0.addr;
        wdata  = m1.gnt ? m1.colr : m0.colr;
    end

    // flip only after a contested grant
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            prio <= 1'b0;
        end else if (m0.req && m1.req) begin
            prio <= ~prio;
        end
    end

endmodule

/* fb_clock_gen.sv */
// testbench clock and reset source, 10 ns pixel clock
// reset held low over the first three rising edges
`timescale 1ns/10ps

module fb_clock_gen (
    output logic clk_pix,
    output logic rst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 100 MHz
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n = 1'b1;  // released on a falling edge
    end

endmodule

/* fb_pkg.sv */
// shared constants and command word layout for the framebuffer design
// referenced by scoped name from every block
package fb_pkg;

    localparam int CORDW = 10;  // screen coordinate width

    // 640x480 timing, widths match sx/sy
    localparam logic [CORDW-1:0] H_ACTIVE = 10'd640;
    localparam logic [CORDW-1:0] H_FRONT  = 10'd16;
    localparam logic [CORDW-1:0] H_SYNC   = 10'd96;
    localparam logic [CORDW-1:0] H_BACK   = 10'd48;
    localparam logic [CORDW-1:0] H_TOTAL  = 10'd800;
    localparam logic [CORDW-1:0] V_ACTIVE = 10'd480;
    localparam logic [CORDW-1:0] V_FRONT  = 10'd10;
    localparam logic [CORDW-1:0] V_SYNC   = 10'd2;
    localparam logic [CORDW-1:0] V_BACK   = 10'd33;
    localparam logic [CORDW-1:0] V_TOTAL  = 10'd525;

    // framebuffer geometry, part-selected where narrower
    localparam int FB_ADDRW = 15;
    localparam int FB_XW    = 8;
    localparam int FB_YW    = 7;
    localparam int COLRW    = 4;  // grey levels
    localparam logic [FB_ADDRW-1:0] FB_WIDTH  = 15'd160;
    localparam logic [FB_ADDRW-1:0] FB_HEIGHT = 15'd120;
    localparam logic [FB_ADDRW-1:0] FB_PIXELS = 15'd19200;

    localparam logic [1:0] OP_NOP   = 2'd0;
    localparam logic [1:0] OP_POKE  = 2'd1;
    localparam logic [1:0] OP_HLINE = 2'd2;
    localparam logic [1:0] OP_VLINE = 2'd3;

    localparam logic [7:0] ADDR_CMD    = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;

    // command word, opcode always in 31:30
    typedef union packed {
        struct packed {
            logic [1:0]       op;
            logic [FB_XW-1:0] x;
            logic [FB_YW-1:0] y;
            logic [7:0]       len;   // length minus one
            logic [COLRW-1:0] colr;
            logic [2:0]       rsvd;
        } line;
        struct packed {
            logic [1:0]          op;
            logic [FB_ADDRW-1:0] addr;  // linear y*160+x
            logic [COLRW-1:0]    colr;
            logic [10:0]         rsvd;
        } pix;
    } fb_cmd_u;

endpackage

/* fb_top.f */
fb_pkg.sv
fb_wr_if.sv
display_timings.sv
fb_apb_regs.sv
line_drawer.sv
fb_arbiter.sv
framebuffer_ram.sv
vga_scanout.sv
fb_top.sv
fb_top_checker.sv
fb_clock_gen.sv
fb_top_tb.sv

/* fb_top.sv */
// framebuffer subsystem top: APB host commands in, VGA out
// pokes and the line drawer share the RAM write port via the arbiter
`timescale 1ns/10ps

module fb_top (
    input  logic         clk_pix,
    input  logic         rst_n,
    input  logic [7:0]   paddr,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    output logic         vga_hsync,
    output logic         vga_vsync,
    output logic [3:0]   vga_r,
    output logic [3:0]   vga_g,
    output logic [3:0]   vga_b
);

    logic [fb_pkg::CORDW-1:0]    sx, sy;
    logic                        hsync, vsync, frame;
    logic                        busy, start;
    fb_pkg::fb_cmd_u             cmd;
    logic                        we;
    logic [fb_pkg::FB_ADDRW-1:0] waddr, raddr;
    logic [fb_pkg::COLRW-1:0]    wdata, rdata;

    fb_wr_if poke_if ();  // master 0
    fb_wr_if draw_if ();  // master 1

    display_timings display_timings_inst (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .frame
    );

    fb_apb_regs fb_apb_regs_inst (
        .clk_pix, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .busy, .start, .cmd, .poke(poke_if)
    );

    line_drawer line_drawer_inst (
        .clk_pix, .rst_n, .start, .cmd, .busy, .wr(draw_if)
    );

    fb_arbiter fb_arbiter_inst (
        .clk_pix, .rst_n, .m0(poke_if), .m1(draw_if), .we, .waddr, .wdata
    );

    framebuffer_ram framebuffer_ram_inst (
        .clk_pix, .we, .waddr, .wdata, .raddr, .rdata
    );

    vga_scanout vga_scanout_inst (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .frame, .raddr, .rdata,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

/* fb_top_checker.sv */
// concurrent assertions on the write arbiter
// bound into every fb_arbiter instance below
`timescale 1ns/10ps

module fb_top_checker (
    input logic                          clk_pix,
    input logic                          rst_n,
    input logic                          m0_req,
    input logic                          m0_gnt,
    input logic [fb_pkg::FB_ADDRW-1:0]   m0_addr,
    input logic                          m1_req,
    input logic                          m1_gnt,
    input logic [fb_pkg::FB_ADDRW-1:0]   m1_addr,
    input logic                          we
);

    a_one_grant: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(m0_gnt && m1_gnt)) else $error("arbiter granted both masters");

    a_gnt_needs_req: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (!m0_gnt || m0_req) && (!m1_gnt || m1_req)) else $error("grant without request");

    a_we_matches: assert property (@(posedge clk_pix) disable iff (!rst_n)
        we == (m0_gnt || m1_gnt)) else $error("write enable differs from grants");

    // waiting master keeps its address
    a_m0_hold: assert property (@(posedge clk_pix) disable iff (!rst_n)
        m0_req && !m0_gnt |=> m0_addr == $past(m0_addr)) else $error("poke address moved");
    a_m1_hold: assert property (@(posedge clk_pix) disable iff (!rst_n)
        m1_req && !m1_gnt |=> m1_addr == $past(m1_addr)) else $error("line address moved");

endmodule

bind fb_arbiter fb_top_checker i_checker (
    .clk_pix, .rst_n,
    .m0_req(m0.req), .m0_gnt(m0.gnt), .m0_addr(m0.addr),
    .m1_req(m1.req), .m1_gnt(m1.gnt), .m1_addr(m1.addr),
    .we
);

/* fb_top_tb.sv */
// directed tests of the framebuffer subsystem driven over APB
// VGA output compared against a pixel model two cycles behind the beam
`timescale 1ns/10ps

module fb_top_tb;

    localparam int FRAME_CYCLES = 420000;           // 800 x 525 positions
    localparam int LIMIT        = 6 * 2 * FRAME_CYCLES;  // six tests of two frames each

    logic        clk_pix, rst_n;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [31:0] pwdata, prdata;
    logic        vga_hsync, vga_vsync;
    logic [3:0]  vga_r, vga_g, vga_b;
    logic [3:0]  model [19200];       // expected framebuffer
    int          errors = 0;
    int          cyc = 0;             // rising edges since release
    int          seed = 32'hc2fd4aea;

    fb_clock_gen i_clk (.clk_pix, .rst_n);

    fb_top i_dut (
        .clk_pix, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
        .pready, .pslverr, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

    always @(posedge clk_pix) begin
        if (!rst_n) cyc <= 0;
        else cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout: simulation did not finish within %0d cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic [14:0] pix_index(input int x, input int y);
        return 15'(y * 160 + x);  // row major over 160 columns
    endfunction

    function automatic logic [3:0] rand_colr();
        int r;
        r = $random(seed);
        return r[3:0];
    endfunction

    // one APB transfer that waits out any stall
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk_pix);
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_pix);
        penable = 1'b1;
        #2;
        while (!pready) begin
            @(negedge clk_pix);
            #2;
        end
        rdata = prdata;  // completes at the next rising edge
        err   = pslverr;
        @(negedge clk_pix);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic poke(input int addr, input logic [3:0] colr);
        logic [31:0] d;
        logic e;
        apb_xfer(1'b1, 8'h00, {fb_pkg::OP_POKE, 15'(addr), colr, 11'b0}, d, e);
        check("poke_cmd", 32'h0, 32'(e));
        if (addr < 19200) model[15'(addr)] = colr;  // else dropped
    endtask

    task automatic draw_line(input logic vert, input int x, input int y, input int len,
                             input logic [3:0] colr);
        logic [31:0] d;
        logic e;
        int i, px, py;
        apb_xfer(1'b1, 8'h00, {vert ? fb_pkg::OP_VLINE : fb_pkg::OP_HLINE,
                 8'(x), 7'(y), 8'(len - 1), colr, 3'b0}, d, e);
        check("line_cmd", 32'h0, 32'(e));
        for (i = 0; i < len; i++) begin
            px = vert ? x : x + i;
            py = vert ? y + i : y;
            if (px >= 160 || py >= 120) break;  // run stops at the edge
            model[pix_index(px, py)] = colr;
        end
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        logic e;
        d = 32'h3;
        while (d[1:0] != 2'b00) apb_xfer(1'b0, 8'h04, 32'h0, d, e);  // until busy and pending clear
    endtask

    task automatic check_frame(input string name);
        int i, x, y;
        logic [3:0] c;
        logic [13:0] expv;
        @(negedge clk_pix);
        // outputs show position index cyc-2
        while ((cyc - 2) % FRAME_CYCLES != 0) @(negedge clk_pix);
        for (i = 0; i < FRAME_CYCLES; i++) begin
            x = i % 800;
            y = i / 800;
            c = (x < 160 && y < 120) ? model[pix_index(x, y)] : 4'h0;
            expv = {!(x >= 656 && x <= 751), !(y == 490 || y == 491), c, c, c};
            check(name, 32'(expv), 32'({vga_hsync, vga_vsync, vga_r, vga_g, vga_b}));
            @(negedge clk_pix);
        end
    endtask

    task automatic test_reset();
        logic [31:0] d;
        logic e;
        @(negedge clk_pix);  // still in reset
        check("reset", 32'h6001, 32'({vga_hsync, vga_vsync, vga_r, vga_g, vga_b, pready}));
        wait (rst_n);
        apb_xfer(1'b0, 8'h04, 32'h0, d, e);
        check("reset_status", 32'h0, d);
    endtask

    task automatic test_pokes();
        int a;
        for (a = 0; a < 19200; a++) poke(a, rand_colr());  // whole area
        wait_idle();
        check_frame("pokes");
    endtask

    task automatic test_lines();
        draw_line(1'b0, 10, 20, 50, rand_colr());
        draw_line(1'b1, 30, 5, 60, rand_colr());
        draw_line(1'b0, 0, 119, 160, rand_colr());  // bottom row
        wait_idle();
        check_frame("lines");
    endtask

    task automatic test_clipping();
        draw_line(1'b0, 150, 40, 20, rand_colr());  // ten pixels land
        draw_line(1'b1, 70, 115, 10, rand_colr());
        draw_line(1'b0, 200, 10, 5, rand_colr());   // starts off the buffer
        draw_line(1'b1, 5, 125, 3, rand_colr());
        poke(19200, rand_colr());
        wait_idle();
        check_frame("clipping");
    endtask

    task automatic test_arbitration();
        int i;
        draw_line(1'b0, 0, 60, 160, rand_colr());
        for (i = 0; i < 6; i++) poke(110 * 160 + 3 * i, rand_colr());  // contend with run
        draw_line(1'b1, 80, 0, 120, rand_colr());  // stalls behind first run
        for (i = 0; i < 6; i++) poke(100 * 160 + 90 + i, rand_colr());
        wait_idle();
        check_frame("arbitration");
    endtask

    task automatic test_bus_errors();
        logic [31:0] d;
        logic e;
        // poke word at a wrong offset, colour differs from pixel 0
        apb_xfer(1'b1, 8'h08, {fb_pkg::OP_POKE, 15'd0, ~model[0], 11'b0}, d, e);
        check("bus_errors", 32'h1, 32'(e));
        apb_xfer(1'b0, 8'h0c, 32'h0, d, e);
        check("bus_errors", 32'h1, 32'(e));
        // NOP with junk payload
        apb_xfer(1'b1, 8'h00, {fb_pkg::OP_NOP, 15'd0, ~model[0], 11'h456}, d, e);
        check("bus_errors", 32'h0, 32'(e));
        wait_idle();
        check_frame("bus_errors");
    endtask

    initial begin
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        test_reset();
        test_pokes();
        test_lines();
        test_clipping();
        test_arbitration();
        test_bus_errors();
        $display("%0d errors", errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

endmodule

/* fb_wr_if.sv */
// framebuffer write request between one master and the arbiter
// master holds req, addr and colr until gnt is seen at a clock edge
`timescale 1ns/10ps

interface fb_wr_if;

    logic                          req;   // write wanted
    logic                          gnt;   // write happens this edge
    logic [fb_pkg::FB_ADDRW-1:0]   addr;  // linear pixel address
    logic [fb_pkg::COLRW-1:0]      colr;  // grey value

    modport master (
        output req, addr, colr,
        input  gnt
    );

    modport arbiter (
        input  req, addr, colr,
        output gnt
    );

endinterface

/* framebuffer_ram.sv */
// simple dual port pixel memory for the 160x120 framebuffer
// one write port, registered read with one cycle latency
`timescale 1ns/10ps

module framebuffer_ram (
    input  logic                          clk_pix,
    input  logic                          we,
    input  logic [fb_pkg::FB_ADDRW-1:0]   waddr,
    input  logic [fb_pkg::COLRW-1:0]      wdata,
    input  logic [fb_pkg::FB_ADDRW-1:0]   raddr,
    output logic [fb_pkg::COLRW-1:0]      rdata
);

    logic [fb_pkg::COLRW-1:0] mem [fb_pkg::FB_PIXELS];  // block RAM

    always_ff @(posedge clk_pix) begin
        if (we) mem[waddr] <= wdata;
    end

    always_ff @(posedge clk_pix) begin
        rdata <= mem[raddr];  // data follows address by one cycle
    end

endmodule

/* line_drawer.sv */
// draws a horizontal or vertical run one pixel per grant
// clips at the framebuffer edge, busy low again when the run ends
`timescale 1ns/10ps

module line_drawer (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             start,
    input  fb_pkg::fb_cmd_u  cmd,
    output logic             busy,
    fb_wr_if.master          wr
);

    logic [fb_pkg::FB_XW-1:0]    x;
    logic [fb_pkg::FB_YW-1:0]    y;
    logic [7:0]                  cnt;   // pixels left minus one
    logic                        vert;  // step y instead of x
    logic [fb_pkg::COLRW-1:0]    colr;
    logic in_range, last;

    always_comb begin
        in_range = (x < fb_pkg::FB_WIDTH[fb_pkg::FB_XW-1:0]) &&
                   (y < fb_pkg::FB_HEIGHT[fb_pkg::FB_YW-1:0]);
        // count out or next step crosses the edge
        last = (cnt == '0) ||
               (vert ? (y == fb_pkg::FB_HEIGHT[fb_pkg::FB_YW-1:0] - 1'b1)
                     : (x == fb_pkg::FB_WIDTH[fb_pkg::FB_XW-1:0] - 1'b1));
        wr.req  = busy && in_range;  // clipped first pixel never requests
        wr.colr = colr;
        wr.addr = {{(fb_pkg::FB_ADDRW-fb_pkg::FB_YW){1'b0}}, y} * fb_pkg::FB_WIDTH
                + {{(fb_pkg::FB_ADDRW-fb_pkg::FB_XW){1'b0}}, x};
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (busy && (!in_range || (wr.gnt && last))) begin
            busy <= 1'b0;
        end
    end

    // position walk
    always_ff @(posedge clk_pix) begin
        if (start) begin
            x    <= cmd.line.x;
            y    <= cmd.line.y;
            cnt  <= cmd.line.len;
            colr <= cmd.line.colr;
            vert <= (cmd.line.op == fb_pkg::OP_VLINE);
        end else if (busy && wr.gnt) begin
            if (vert) y <= y + 1'b1;
            else x <= x + 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the framebuffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fb_top_tb \
    -f fb_top.f -Mdir obj_dir -o fb_top_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/fb_top_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* vga_scanout.sv */
// reads the framebuffer in step with the beam and drives the VGA pins
// pixel and sync for a position leave two cycles after sx/sy
`timescale 1ns/10ps

module vga_scanout (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    input  logic [fb_pkg::CORDW-1:0]      sx,
    input  logic [fb_pkg::CORDW-1:0]      sy,
    input  logic                          hsync,
    input  logic                          vsync,
    input  logic                          frame,
    output logic [fb_pkg::FB_ADDRW-1:0]   raddr,
    input  logic [fb_pkg::COLRW-1:0]      rdata,
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic [3:0]                    vga_r,
    output logic [3:0]                    vga_g,
    output logic [3:0]                    vga_b
);

    logic [fb_pkg::FB_ADDRW-1:0] addr_q;  // next address to read
    logic paint, paint_p1, hsync_p1, vsync_p1;

    always_comb begin
        // top-left 160x120 window
        paint = (sx < fb_pkg::FB_WIDTH[fb_pkg::CORDW-1:0]) &&
                (sy < fb_pkg::FB_HEIGHT[fb_pkg::CORDW-1:0]);
        raddr = frame ? '0 : addr_q;  // address 0 already at 0,0
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            addr_q    <= '0;
            paint_p1  <= 1'b0;
            hsync_p1  <= 1'b1;
            vsync_p1  <= 1'b1;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            if (paint) addr_q <= raddr + 1'b1;
            paint_p1  <= paint;  // align with RAM read
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= paint_p1 ? rdata : 4'h0;  // grey, same on all three
            vga_g     <= paint_p1 ? rdata : 4'h0;
            vga_b     <= paint_p1 ? rdata : 4'h0;
        end
    end

endmodule
